/* tb.f */
hdl/soc_io_pkg.sv
hdl/io_regs.sv
hdl/sdm_channel.sv
hdl/io_readback.sv
hdl/tick_timer.sv
hdl/soc_io_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

/* Makefile */
TOP = tb_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f tb.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int RESET_CYCLES   = 10;
  localparam int NUM_CYCLES     = 3000;  // Random bus cycles
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 100;

  logic                                 clk;
  logic                                 reset_button;
  logic                                 io_rd;
  logic                                 io_wr;
  soc_io_pkg::data_t                    io_addr;
  soc_io_pkg::data_t                    io_dout;
  soc_io_pkg::data_t                    io_din;
  soc_io_pkg::pmod_t                    pmod_in;
  soc_io_pkg::pmod_t                    pmod_out;
  soc_io_pkg::pmod_t                    pmod_dir;
  logic [soc_io_pkg::NUM_CHANNELS-1:0]  rgb;
  logic                                 interrupt;
  int                                   error_count;
  int                                   check_count;
  int                                   cycle_count;

  tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (
    .clk          (clk),
    .reset_button (reset_button)
  );

  soc_io_top dut (
    .clk          (clk),
    .reset_button (reset_button),
    .io_rd        (io_rd),
    .io_wr        (io_wr),
    .io_addr      (io_addr),
    .io_dout      (io_dout),
    .io_din       (io_din),
    .pmod_in      (pmod_in),
    .pmod_out     (pmod_out),
    .pmod_dir     (pmod_dir),
    .rgb          (rgb),
    .interrupt    (interrupt)
  );

  tb_checker u_checker (
    .clk          (clk),
    .reset_button (reset_button),
    .io_wr        (io_wr),
    .io_addr      (io_addr),
    .io_dout      (io_dout),
    .io_din       (io_din),
    .pmod_in      (pmod_in),
    .pmod_out     (pmod_out),
    .pmod_dir     (pmod_dir),
    .rgb          (rgb),
    .interrupt    (interrupt),
    .error_count  (error_count),
    .check_count  (check_count)
  );

  // Reads only with the pins held low so every readback is zero
  task automatic drive_reset_read();
    io_rd   <= 1'b1;
    io_wr   <= 1'b0;
    io_addr <= 16'($urandom);
    io_dout <= 16'($urandom);
    pmod_in <= '0;
  endtask

  // One bus cycle weighted toward live registers
  task automatic drive_random_cycle();
    int                kind;
    logic [1:0]        op;
    bit                write;
    soc_io_pkg::data_t addr;
    soc_io_pkg::data_t data;
    kind  = int'($urandom_range(0, 15));
    op    = 2'($urandom);
    write = 1'($urandom);
    data  = 16'($urandom);
    case (kind)
      0, 1, 2: addr = 16'h0200 | 16'(op);                              // PMOD out
      3, 4:    addr = 16'h0400 | 16'(op);                              // PMOD dir
      5, 6:    addr = 16'h08B0 | 16'(op);                              // LED register
      7, 8, 9: addr = 16'h08C0 + 16'($urandom_range(0, 2) << 4);      // Channel level
      10:      addr = 16'h4000;                                        // Ticks
      11:      addr = 16'h8000;                                        // Read-only cycles
      12:      addr = 16'h0100;                                        // PMOD pins
      13:      addr = 16'($urandom);                                   // Any bit mix
      14:      addr = 16'h0800 | 16'($urandom_range(0, 10) << 4);     // Dropped selectors
      default: begin
        addr  = 16'h4000;  // Preload just below the wrap
        write = 1'b1;
        data  = 16'hFFFF - 16'($urandom_range(0, 7));
      end
    endcase
    io_wr   <= write;
    io_rd   <= !write;
    io_addr <= addr;
    io_dout <= data;
    pmod_in <= soc_io_pkg::pmod_t'($urandom);
  endtask

  task automatic finish_run(input bit timed_out);
    int failures;
    failures = error_count + (timed_out ? 1 : 0);
    $display("Checks %0d, mismatches %0d, timeouts %0d",
             check_count, error_count, timed_out ? 1 : 0);
    if (failures == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  endtask

  initial begin
    io_rd   <= 1'b0;
    io_wr   <= 1'b0;
    io_addr <= '0;
    io_dout <= '0;
    pmod_in <= '0;
    void'($urandom(68));  // One seed for the whole run
    @(posedge clk);
    while (reset_button) begin
      drive_reset_read();
      @(posedge clk);
    end
    repeat (NUM_CYCLES) begin
      drive_random_cycle();
      @(posedge clk);
    end
    io_wr   <= 1'b0;
    io_rd   <= 1'b0;
    io_addr <= '0;
    repeat (2) @(posedge clk);  // Last falling edge check done
    finish_run(1'b0);
  end

  // Run length bound
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: stimulus did not complete within %0d cycles", TIMEOUT_CYCLES);
    finish_run(1'b1);
  end

endmodule

`default_nettype wire

/* bench/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  wire                                  clk,
  input  wire                                  reset_button,
  input  wire                                  io_wr,
  input  soc_io_pkg::data_t                    io_addr,
  input  soc_io_pkg::data_t                    io_dout,
  input  soc_io_pkg::data_t                    io_din,
  input  soc_io_pkg::pmod_t                    pmod_in,
  input  soc_io_pkg::pmod_t                    pmod_out,
  input  soc_io_pkg::pmod_t                    pmod_dir,
  input  wire [soc_io_pkg::NUM_CHANNELS-1:0]   rgb,
  input  wire                                  interrupt,
  output int                                   error_count,
  output int                                   check_count
);

  // Model state, mirrors the registers after the last edge
  soc_io_pkg::pmod_t                    m_pmod_out;
  soc_io_pkg::pmod_t                    m_pmod_dir;
  logic [soc_io_pkg::NUM_CHANNELS-1:0]  m_leds;
  soc_io_pkg::data_t                    m_level [soc_io_pkg::NUM_CHANNELS];
  soc_io_pkg::data_t                    m_phase [soc_io_pkg::NUM_CHANNELS];
  logic [soc_io_pkg::NUM_CHANNELS-1:0]  m_carry;     // Sigma-delta pulse
  soc_io_pkg::data_t                    m_ticks;
  soc_io_pkg::data_t                    m_cycles;    // Edges since reset release
  logic                                 m_irq;
  bit                                   model_valid; // Set by the first reset edge

  initial begin
    error_count = 0;
    check_count = 0;
    model_valid = 1'b0;
  end

  // Write, clear, set, toggle as selected by the low address bits
  function automatic soc_io_pkg::data_t next_reg_value(
    input logic [1:0]         op,
    input soc_io_pkg::data_t  cur,
    input soc_io_pkg::data_t  val
  );
    soc_io_pkg::data_t res;
    case (op)
      2'd0:    res = val;         // Write
      2'd1:    res = cur & ~val;  // Clear
      2'd2:    res = cur | val;   // Set
      default: res = cur ^ val;   // Toggle
    endcase
    return res;
  endfunction

  // OR of every source that the address selects
  function automatic soc_io_pkg::data_t expected_din(input soc_io_pkg::data_t addr);
    soc_io_pkg::data_t v;
    int                sel;
    v   = '0;
    sel = int'(addr[7:4]);
    if (addr[8])  v = v | 16'(pmod_in);
    if (addr[9])  v = v | 16'(m_pmod_out);
    if (addr[10]) v = v | 16'(m_pmod_dir);
    if (addr[11]) begin
      if (sel == 11) v = v | 16'(m_leds);  // LED register
      for (int k = 0; k < soc_io_pkg::NUM_CHANNELS; k++) begin
        if (sel == 12 + k) v = v | m_level[k];
      end
    end
    if (addr[14]) v = v | m_ticks;
    if (addr[15]) v = v | m_cycles;
    return v;  // Bits 12, 13 and selectors 0..10 add nothing
  endfunction

  task automatic check_value(
    input string              name,
    input soc_io_pkg::data_t  got,
    input soc_io_pkg::data_t  exp
  );
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Mismatch %s: dut=%h model=%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_outputs();
    check_value("pmod_out", 16'(pmod_out), 16'(m_pmod_out));
    check_value("pmod_dir", 16'(pmod_dir), 16'(m_pmod_dir));
    for (int k = 0; k < soc_io_pkg::NUM_CHANNELS; k++) begin
      check_value($sformatf("rgb[%0d]", k), 16'(rgb[k]), 16'(m_leds[k] | m_carry[k]));
    end
    check_value("interrupt", 16'(interrupt), 16'(m_irq));
    check_value("io_din", io_din, expected_din(io_addr));
  endtask

  // Applies the inputs that the next rising edge will see
  task automatic update_model();
    logic [1:0]                          op;
    int                                  sel;
    soc_io_pkg::data_t                   leds_next;
    logic [soc_io_pkg::DATA_W:0]         sum;
    logic [soc_io_pkg::DATA_W:0]         ticks_inc;
    op  = io_addr[1:0];
    sel = int'(io_addr[7:4]);
    if (reset_button) begin
      m_pmod_out = '0;
      m_pmod_dir = '0;
      m_leds     = '0;
      m_carry    = '0;
      m_ticks    = '0;
      m_cycles   = '0;
      m_irq      = 1'b0;
      for (int k = 0; k < soc_io_pkg::NUM_CHANNELS; k++) begin
        m_level[k] = '0;
        m_phase[k] = '0;
      end
      model_valid = 1'b1;
    end else begin
      if (io_wr && io_addr[9])
        m_pmod_out = soc_io_pkg::pmod_t'(next_reg_value(op, 16'(m_pmod_out), io_dout));
      if (io_wr && io_addr[10])
        m_pmod_dir = soc_io_pkg::pmod_t'(next_reg_value(op, 16'(m_pmod_dir), io_dout));
      if (io_wr && io_addr[11] && sel == 11) begin
        leds_next = next_reg_value(op, 16'(m_leds), io_dout);
        m_leds    = leds_next[soc_io_pkg::NUM_CHANNELS-1:0];
      end
      for (int k = 0; k < soc_io_pkg::NUM_CHANNELS; k++) begin
        sum        = {1'b0, m_phase[k]} + {1'b0, m_level[k]};  // Old level
        m_phase[k] = sum[soc_io_pkg::DATA_W-1:0];
        m_carry[k] = sum[soc_io_pkg::DATA_W];
        if (io_wr && io_addr[11] && sel == 12 + k) m_level[k] = io_dout;
      end
      ticks_inc = {1'b0, m_ticks} + 17'd1;
      m_irq     = ticks_inc[soc_io_pkg::DATA_W];  // Carry counts even on a load
      if (io_wr && io_addr[14])
        m_ticks = io_dout;
      else
        m_ticks = ticks_inc[soc_io_pkg::DATA_W-1:0];
      m_cycles = m_cycles + 16'd1;
    end
  endtask

  // Falling edge, away from stimulus and register updates
  always @(negedge clk) begin
    if (model_valid) compare_outputs();
    update_model();
  end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset_button
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    reset_button <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_button <= 1'b0;  // Released on a rising edge
  end

endmodule

`default_nettype wire

/* hdl/soc_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_io_top (
  input  wire                                  clk,
  input  wire                                  reset_button,
  input  wire                                  io_rd,     // Reads have no side effect
  input  wire                                  io_wr,
  input  soc_io_pkg::data_t                    io_addr,
  input  soc_io_pkg::data_t                    io_dout,
  output soc_io_pkg::data_t                    io_din,
  input  soc_io_pkg::pmod_t                    pmod_in,
  output soc_io_pkg::pmod_t                    pmod_out,
  output soc_io_pkg::pmod_t                    pmod_dir,  // 1 drives the pin
  output logic [soc_io_pkg::NUM_CHANNELS-1:0]  rgb,       // 0 red, 1 green, 2 blue
  output logic                                 interrupt  // One cycle per tick wrap
);

  logic [soc_io_pkg::NUM_CHANNELS-1:0] leds;
  logic [soc_io_pkg::NUM_CHANNELS-1:0] level_wr;   // Per channel duty strobe
  soc_io_pkg::data_t                   levels [soc_io_pkg::NUM_CHANNELS];
  soc_io_pkg::data_t                   ticks;
  soc_io_pkg::data_t                   cycles;

  // Write side of PMOD, LEDs and channel strobes
  io_regs u_io_regs (
    .clk          (clk),
    .reset_button (reset_button),
    .io_wr        (io_wr),
    .io_addr      (io_addr),
    .io_dout      (io_dout),
    .pmod_out     (pmod_out),
    .pmod_dir     (pmod_dir),
    .leds         (leds),
    .level_wr     (level_wr)
  );

  // One modulator per colour
  for (genvar k = 0; k < soc_io_pkg::NUM_CHANNELS; k++) begin : g_sdm
    sdm_channel u_sdm (
      .clk          (clk),
      .reset_button (reset_button),
      .level_wr     (level_wr[k]),
      .io_dout      (io_dout),
      .led_static   (leds[k]),
      .level        (levels[k]),
      .pulse_out    (rgb[k])
    );
  end

  io_readback u_io_readback (
    .io_addr  (io_addr),
    .pmod_in  (pmod_in),
    .pmod_out (pmod_out),
    .pmod_dir (pmod_dir),
    .leds     (leds),
    .levels   (levels),
    .ticks    (ticks),
    .cycles   (cycles),
    .io_din   (io_din)
  );

  // Decodes its own load from bit 14
  tick_timer u_tick_timer (
    .clk          (clk),
    .reset_button (reset_button),
    .io_wr        (io_wr),
    .io_addr      (io_addr),
    .io_dout      (io_dout),
    .ticks        (ticks),
    .cycles       (cycles),
    .interrupt    (interrupt)
  );

endmodule

`default_nettype wire

/* hdl/tick_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_timer (
  input  wire                clk,
  input  wire                reset_button,
  input  wire                io_wr,
  input  soc_io_pkg::data_t  io_addr,
  input  soc_io_pkg::data_t  io_dout,
  output soc_io_pkg::data_t  ticks,
  output soc_io_pkg::data_t  cycles,
  output logic               interrupt
);

  logic [soc_io_pkg::DATA_W:0] ticks_plus_1;  // Carry out lands in the top bit
  logic                        ticks_load;

  assign ticks_plus_1 = {1'b0, ticks} + 1'b1;
  assign ticks_load   = io_wr & io_addr[soc_io_pkg::TICKS_BIT];

  always_ff @(posedge clk) begin
    if (reset_button) begin
      ticks     <= '0;
      cycles    <= '0;
      interrupt <= 1'b0;
    end else begin
      if (ticks_load)
        ticks <= io_dout;  // Software preload
      else
        ticks <= ticks_plus_1[soc_io_pkg::DATA_W-1:0];
      // Wrap flag taken even when a load wins
      interrupt <= ticks_plus_1[soc_io_pkg::DATA_W];
      cycles    <= cycles + 1'b1;  // Free running
    end
  end

  // Interrupt only ever follows an all-ones count
  a_irq_after_wrap: assert property (
    @(posedge clk) disable iff (reset_button)
    interrupt |-> $past(ticks) == '1
  );

endmodule

`default_nettype wire

/* hdl/io_readback.sv */
`timescale 1ns/1ps
`default_nettype none

module io_readback (
  input  soc_io_pkg::data_t                    io_addr,
  input  soc_io_pkg::pmod_t                    pmod_in,
  input  soc_io_pkg::pmod_t                    pmod_out,
  input  soc_io_pkg::pmod_t                    pmod_dir,
  input  wire [soc_io_pkg::NUM_CHANNELS-1:0]   leds,
  input  soc_io_pkg::data_t                    levels [soc_io_pkg::NUM_CHANNELS],
  input  soc_io_pkg::data_t                    ticks,
  input  soc_io_pkg::data_t                    cycles,
  output soc_io_pkg::data_t                    io_din
);

  logic [soc_io_pkg::SEL_W-1:0] sel;
  logic                         periph;  // Selector field is valid

  assign sel    = io_addr[soc_io_pkg::SEL_LSB +: soc_io_pkg::SEL_W];
  assign periph = io_addr[soc_io_pkg::PERIPH_BIT];

  // Every hit source ORs in, zero-extended to the bus
  always_comb begin
    io_din = '0;

    if (io_addr[soc_io_pkg::PMOD_IN_BIT])
      io_din = io_din | soc_io_pkg::data_t'(pmod_in);
    if (io_addr[soc_io_pkg::PMOD_OUT_BIT])
      io_din = io_din | soc_io_pkg::data_t'(pmod_out);
    if (io_addr[soc_io_pkg::PMOD_DIR_BIT])
      io_din = io_din | soc_io_pkg::data_t'(pmod_dir);

    // LED register, no pin readback here
    if (periph && sel == soc_io_pkg::SEL_W'(soc_io_pkg::SEL_LEDS))
      io_din = io_din | soc_io_pkg::data_t'(leds);

    for (int k = 0; k < soc_io_pkg::NUM_CHANNELS; k++) begin
      if (periph && sel == soc_io_pkg::SEL_W'(soc_io_pkg::SEL_SDM_BASE + k))
        io_din = io_din | levels[k];  // Channel duty
    end

    if (io_addr[soc_io_pkg::TICKS_BIT])
      io_din = io_din | ticks;
    if (io_addr[soc_io_pkg::CYCLES_BIT])
      io_din = io_din | cycles;

    // Bits 12, 13 and the other selectors have no source left, read zero
  end

endmodule

`default_nettype wire

/* hdl/sdm_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module sdm_channel (
  input  wire                clk,
  input  wire                reset_button,
  input  wire                level_wr,
  input  soc_io_pkg::data_t  io_dout,
  input  wire                led_static,
  output soc_io_pkg::data_t  level,
  output logic               pulse_out
);

  soc_io_pkg::data_t              phase;   // Accumulator, wraps modulo 65536
  logic                           carry;   // Registered overflow of phase
  logic [soc_io_pkg::DATA_W:0]    sum;     // One extra bit for the carry

  assign sum = {1'b0, phase} + {1'b0, level};

  always_ff @(posedge clk) begin
    if (reset_button) begin
      level <= '0;
      phase <= '0;
      carry <= 1'b0;
    end else begin
      if (level_wr) level <= io_dout;  // New duty from the bus
      // Carry density is level/65536
      {carry, phase} <= sum;
    end
  end

  assign pulse_out = led_static | carry;  // Static bit forces the LED on

  // Carry comes from the level of the cycle before
  a_dark_when_idle: assert property (
    @(posedge clk) disable iff (reset_button)
    ($past(level) == '0 && !led_static) |-> !pulse_out
  );

endmodule

`default_nettype wire

/* hdl/io_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module io_regs (
  input  wire                                  clk,
  input  wire                                  reset_button,
  input  wire                                  io_wr,
  input  soc_io_pkg::data_t                    io_addr,
  input  soc_io_pkg::data_t                    io_dout,
  output soc_io_pkg::pmod_t                    pmod_out,
  output soc_io_pkg::pmod_t                    pmod_dir,
  output logic [soc_io_pkg::NUM_CHANNELS-1:0]  leds,
  output logic [soc_io_pkg::NUM_CHANNELS-1:0]  level_wr
);

  soc_io_pkg::wr_op_t               op;
  logic [soc_io_pkg::SEL_W-1:0]     sel;
  logic                             periph_wr;  // Write into the selector space
  logic                             out_wr;
  logic                             dir_wr;
  logic                             leds_wr;
  soc_io_pkg::data_t                out_next;
  soc_io_pkg::data_t                dir_next;
  soc_io_pkg::data_t                leds_next;

  // Write, clear, set or toggle of one register
  function automatic soc_io_pkg::data_t apply_op(
    input soc_io_pkg::wr_op_t op_in,
    input soc_io_pkg::data_t  cur,
    input soc_io_pkg::data_t  val
  );
    case (op_in)
      soc_io_pkg::OP_CLEAR:  return cur & ~val;
      soc_io_pkg::OP_SET:    return cur | val;
      soc_io_pkg::OP_TOGGLE: return cur ^ val;
      default:               return val;  // OP_WRITE
    endcase
  endfunction

  assign op  = soc_io_pkg::wr_op_t'(io_addr[1:0]);
  assign sel = io_addr[soc_io_pkg::SEL_LSB +: soc_io_pkg::SEL_W];

  assign periph_wr = io_wr & io_addr[soc_io_pkg::PERIPH_BIT];
  assign out_wr    = io_wr & io_addr[soc_io_pkg::PMOD_OUT_BIT];  // No selector needed
  assign dir_wr    = io_wr & io_addr[soc_io_pkg::PMOD_DIR_BIT];
  assign leds_wr   = periph_wr & (sel == soc_io_pkg::SEL_W'(soc_io_pkg::SEL_LEDS));

  // Next values worked at full bus width, cut down on the way in
  assign out_next  = apply_op(op, soc_io_pkg::data_t'(pmod_out), io_dout);
  assign dir_next  = apply_op(op, soc_io_pkg::data_t'(pmod_dir), io_dout);
  assign leds_next = apply_op(op, soc_io_pkg::data_t'(leds), io_dout);

  always_ff @(posedge clk) begin
    if (reset_button) begin
      pmod_out <= '0;
      pmod_dir <= '0;  // All pins start as inputs
      leds     <= '0;
    end else begin
      if (out_wr)  pmod_out <= out_next[soc_io_pkg::PMOD_W-1:0];
      if (dir_wr)  pmod_dir <= dir_next[soc_io_pkg::PMOD_W-1:0];
      if (leds_wr) leds     <= leds_next[soc_io_pkg::NUM_CHANNELS-1:0];
    end
  end

  // One level strobe per channel, selectors 12 and up
  for (genvar k = 0; k < soc_io_pkg::NUM_CHANNELS; k++) begin : g_level_wr
    assign level_wr[k] =
      periph_wr & (sel == soc_io_pkg::SEL_W'(soc_io_pkg::SEL_SDM_BASE + k));
  end

  // A single bus write never reaches two channels
  a_level_wr_onehot: assert property (
    @(posedge clk) disable iff (reset_button) $onehot0(level_wr)
  );

endmodule

`default_nettype wire

/* hdl/soc_io_pkg.sv */
`default_nettype none

package soc_io_pkg;

  // Bus geometry
  localparam int DATA_W       = 16;  // Processor word
  localparam int PMOD_W       = 8;   // PMOD header pins
  localparam int NUM_CHANNELS = 3;   // 0 red, 1 green, 2 blue

  // One-hot address bits, several may be set for an ORed read
  localparam int PMOD_IN_BIT  = 8;   // 0100 pin readback
  localparam int PMOD_OUT_BIT = 9;   // 0200 output latch
  localparam int PMOD_DIR_BIT = 10;  // 0400 direction, 1 drives the pin
  localparam int PERIPH_BIT   = 11;  // 0800 qualifies the selector field
  localparam int TICKS_BIT    = 14;  // 4000 tick counter
  localparam int CYCLES_BIT   = 15;  // 8000 cycle counter

  // Selector field under PERIPH_BIT
  localparam int SEL_LSB      = 4;
  localparam int SEL_W        = 4;   // Bits 7..4
  localparam int SEL_LEDS     = 11;  // 08B0 static LED bits
  localparam int SEL_SDM_BASE = 12;  // 08C0 red, 08D0 green, 08E0 blue

  // Selectors 0..10 belonged to RAM and LCD, now read as zero

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [PMOD_W-1:0] pmod_t;

  // Low two address bits pick how a register takes the written word
  typedef enum logic [1:0] {
    OP_WRITE  = 2'd0,  // Plain load
    OP_CLEAR  = 2'd1,  // Clear bits set in data
    OP_SET    = 2'd2,  // Set bits set in data
    OP_TOGGLE = 2'd3   // Invert bits set in data
  } wr_op_t;

endpackage

`default_nettype wire
